// ==== approx_mul16.f ====
common/mul_arith_pkg.sv
common/mul_pipe_pkg.sv
partial_products/approx_mul8.sv
partial_products/array_mul8.sv
partial_products/partial_product_gen.sv
logic/pp_stage_reg.sv
logic/cla_adder.sv
logic/product_combine.sv
logic/approx_mul16.sv
verification/approx_mul16_chk.sv
verification/approx_mul16_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= approx_mul16_tb
FILELIST  ?= approx_mul16.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test OK

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/approx_mul16_tb.sv ====
// Testbench for the 16x16 approximate multiplier
// Drives random and corner operand pairs, checks latency, error bound,
// exact results for zero low bytes and result count

`default_nettype none

module approx_mul16_tb;

  import mul_arith_pkg::*;

  typedef struct packed {
    operand_t    a;
    operand_t    b;
    int unsigned due;
    logic        exact;
  } pair_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        in_valid;
  operand_t    a;
  operand_t    b;
  logic        out_valid;
  product_t    product;
  pair_t       pending[$];
  int unsigned cycle;
  int          n_in;
  int          n_out;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          err_start;

  approx_mul16 #(.SUM_W(PRODUCT_W)) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .out_valid (out_valid),
    .product   (product)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // Scoreboard, sampled away from the rising edge
  always @(negedge clk) begin
    pair_t    cur;
    product_t expect_p;
    longint   diff;
    if (!rst_n) begin
      assert (out_valid == 1'b0) else begin
        errors++;
        $display("** Error at %0t: out_valid expected 0, actual %b", $time, out_valid);
      end
    end else if (out_valid) begin
      assert (pending.size() != 0) else begin
        errors++;
        $display("out_valid rose at %0t with no operand pair pending", $time);
      end
      if (pending.size() != 0) begin
        cur      = pending.pop_front();
        n_out++;
        expect_p = product_t'(cur.a) * product_t'(cur.b);
        diff     = longint'(product) - longint'(expect_p);
        if (diff < 0) begin
          diff = -diff;
        end
        assert (cycle == cur.due) else begin
          errors++;
          $display("** Error at %0t: out_valid cycle expected %0d, actual %0d",
                   $time, cur.due, cycle);
        end
        if (cur.exact) begin
          assert (product == expect_p) else begin
            errors++;
            $display("** Error at %0t: product expected %h, actual %h",
                     $time, expect_p, product);
          end
        end else begin
          assert (diff <= longint'(APPROX_WCE)) else begin
            errors++;
            $display("** Error at %0t: product expected within %0d of %h, actual %h",
                     $time, APPROX_WCE, expect_p, product);
          end
        end
      end
    end
  end

  task automatic drive_pair(input operand_t a_v, input operand_t b_v, input logic exact_v);
    pair_t entry;
    @(posedge clk);
    #1;
    a        = a_v;
    b        = b_v;
    in_valid = 1'b1;
    // Sampled at the next edge, result two edges after that
    entry.a     = a_v;
    entry.b     = b_v;
    entry.due   = cycle + 2;
    entry.exact = exact_v;
    pending.push_back(entry);
    n_in++;
  endtask

  task automatic drive_idle();
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  function automatic operand_t rand_op();
    return operand_t'($urandom());
  endfunction

  // Waits for all queued results, bounded by max_cycles
  task automatic wait_drain(input int max_cycles);
    int waited;
    waited = 0;
    while (pending.size() != 0 && waited < max_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (pending.size() != 0) begin
      errors++;
      $display("Timeout at %0t: %0d results still missing after %0d cycles",
               $time, pending.size(), max_cycles);
      pending.delete();
    end
  endtask

  task automatic end_test(input string name);
    drive_idle();
    wait_drain(50);
    assert (n_out == n_in) else begin
      errors++;
      $display("** Error at %0t: result count expected %0d, actual %0d", $time, n_in, n_out);
    end
    tests_run++;
    if (errors != err_start) tests_failed++;
    $display("%s test %s, %0d errors", name, (errors == err_start) ? "passed" : "failed",
             errors - err_start);
    err_start = errors;
  endtask

  initial begin
    void'($urandom(32'hbcb4));
    rst_n    = 1'b0;
    in_valid = 1'b0;
    a        = '0;
    b        = '0;
    cycle    = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle after reset, nothing may come out
    repeat (5) begin
      @(negedge clk);
      assert (out_valid == 1'b0) else begin
        errors++;
        $display("** Error at %0t: out_valid expected 0, actual %b", $time, out_valid);
      end
    end
    end_test("reset");

    for (int i = 0; i < 10; i++) begin
      drive_pair(rand_op(), rand_op(), 1'b0);
      repeat ($urandom_range(3)) drive_idle();
    end
    end_test("latency");

    for (int i = 0; i < 200; i++) begin
      drive_pair(rand_op(), rand_op(), 1'b0);
      if ($urandom_range(3) == 0) drive_idle();
    end
    end_test("accuracy");

    // Zero low bytes keep the approximate circuit silent
    for (int i = 0; i < 50; i++) begin
      drive_pair({half_t'($urandom()), 8'h00}, {half_t'($urandom()), 8'h00}, 1'b1);
    end
    end_test("exact");

    for (int i = 0; i < 30; i++) begin
      case (i)
        0:       drive_pair(16'hffff, 16'hffff, 1'b0);
        1:       drive_pair(16'h0000, 16'hffff, 1'b0);
        2:       drive_pair(16'hffff, 16'h0000, 1'b0);
        3:       drive_pair(16'h0001, 16'h0001, 1'b0);
        4:       drive_pair(16'h8000, 16'h8000, 1'b0);
        5:       drive_pair(16'h0080, 16'h0080, 1'b0);
        6:       drive_pair(16'h0001, 16'h8000, 1'b0);
        7:       drive_pair(16'h0100, 16'h00ff, 1'b0);
        default: drive_pair(rand_op(), rand_op(), 1'b0);
      endcase
    end
    end_test("stream");

    $display("Tests run: %0d, failed: %0d, results: %0d of %0d, errors: %0d",
             tests_run, tests_failed, n_out, n_in, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/approx_mul16_chk.sv ====
// Timing and reset checker for the 16x16 approximate multiplier
// Bound to the top level, reports only through failing assertions

`default_nettype none

module approx_mul16_chk (
  input wire clk,
  input wire rst_n,
  input wire in_valid,
  input wire out_valid
);

  // A sampled pair leaves two edges later
  a_latency_fwd: assert property (
    @(posedge clk) disable iff (!rst_n) $past(in_valid, 2) |-> out_valid
  ) else $error("out_valid missing two cycles after in_valid");

  // No result without a pair two edges earlier
  a_latency_rev: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> $past(in_valid, 2)
  ) else $error("out_valid without in_valid two cycles earlier");

  a_reset_low: assert property (
    @(posedge clk) !rst_n |-> !out_valid
  ) else $error("out_valid high while rst_n is low");

  a_known: assert property (
    @(posedge clk) !$isunknown(out_valid)
  ) else $error("out_valid is unknown");

endmodule

bind approx_mul16 approx_mul16_chk u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid)
);

`default_nettype wire

// ==== logic/approx_mul16.sv ====
// 16x16 approximate unsigned multiplier, two-stage pipeline
// Partial products are registered, then aligned, summed and registered
// again, so a result leaves two clocks after its operands

`default_nettype none

module approx_mul16 #(
  parameter int SUM_W = mul_arith_pkg::PRODUCT_W
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          in_valid,
  input  wire mul_arith_pkg::operand_t a,
  input  wire mul_arith_pkg::operand_t b,
  output logic                         out_valid,
  output mul_arith_pkg::product_t      product
);

  import mul_pipe_pkg::*;

  pp_bundle_t pp;
  pp_item_t   item;

  partial_product_gen u_ppgen (
    .a  (a),
    .b  (b),
    .pp (pp)
  );

  pp_stage_reg u_pp_reg (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .pp       (pp),
    .item     (item)
  );

  product_combine #(.SUM_W(SUM_W)) u_combine (
    .clk       (clk),
    .rst_n     (rst_n),
    .item      (item),
    .out_valid (out_valid),
    .product   (product)
  );

endmodule

`default_nettype wire

// ==== logic/product_combine.sv ====
// Partial product accumulation
// Aligns the four 8x8 products, sums them with two chained CLA adders
// and registers the 32-bit result with its valid bit

`default_nettype none

module product_combine #(
  parameter int SUM_W = mul_arith_pkg::PRODUCT_W
) (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire mul_pipe_pkg::pp_item_t item,
  output logic                        out_valid,
  output mul_arith_pkg::product_t     product
);

  import mul_arith_pkg::*;
  import mul_pipe_pkg::*;

  pp_bundle_t       pp;
  logic [SUM_W-1:0] llhh;
  logic [SUM_W-1:0] lh_sh;
  logic [SUM_W-1:0] hl_sh;
  logic [SUM_W-1:0] part_sum;
  logic [SUM_W-1:0] full_sum;

  assign pp = item.pp;

  // hh and ll do not overlap, so one concatenation holds both
  assign llhh  = SUM_W'({pp.hh, pp.ll});
  assign lh_sh = SUM_W'(pp.lh) << HALF_W;
  assign hl_sh = SUM_W'(pp.hl) << HALF_W;

  cla_adder #(.SUM_W(SUM_W)) u_add_lh (.x(llhh), .y(lh_sh), .sum(part_sum));
  cla_adder #(.SUM_W(SUM_W)) u_add_hl (.x(part_sum), .y(hl_sh), .sum(full_sum));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= item.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (item.valid) begin
      product <= product_t'(full_sum);
    end
  end

endmodule

`default_nettype wire

// ==== logic/cla_adder.sv ====
// Carry-lookahead adder
// Four-bit groups; carries into the groups come from a lookahead over
// the group terms, carries inside a group from a local lookahead

`default_nettype none

module cla_adder #(
  parameter int SUM_W = 32
) (
  input  wire  [SUM_W-1:0] x,
  input  wire  [SUM_W-1:0] y,
  output logic [SUM_W-1:0] sum
);

  localparam int NGRP = SUM_W / 4;

  logic [SUM_W-1:0] p;
  logic [SUM_W-1:0] g;
  logic [SUM_W-1:0] c;
  logic [NGRP-1:0]  grp_p;
  logic [NGRP-1:0]  grp_g;
  logic [NGRP-1:0]  grp_c;

  // Carry into position k, written as a flat sum of products
  function automatic logic lookahead(input logic [SUM_W-1:0] gen,
                                     input logic [SUM_W-1:0] prop,
                                     input logic cin, input int k);
    logic carry;
    logic term;
    carry = cin;
    for (int n = 0; n < k; n++) begin
      carry = carry & prop[n];
    end
    for (int m = 0; m < k; m++) begin
      term = gen[m];
      for (int n = m + 1; n < k; n++) begin
        term = term & prop[n];
      end
      carry = carry | term;
    end
    return carry;
  endfunction

  assign p = x ^ y;
  assign g = x & y;

  for (genvar k = 0; k < NGRP; k++) begin : g_grp
    assign grp_p[k] = &p[4*k +: 4];
    assign grp_g[k] = lookahead(SUM_W'(g[4*k +: 4]), SUM_W'(p[4*k +: 4]), 1'b0, 4);
    // Adder has no carry-in
    assign grp_c[k] = lookahead(SUM_W'(grp_g), SUM_W'(grp_p), 1'b0, k);
    for (genvar i = 0; i < 4; i++) begin : g_bit
      assign c[4*k+i] = lookahead(SUM_W'(g[4*k +: 4]), SUM_W'(p[4*k +: 4]), grp_c[k], i);
    end
  end

  assign sum = p ^ c;

endmodule

`default_nettype wire

// ==== logic/pp_stage_reg.sv ====
// Partial product pipeline register
// Holds one bundle with its valid bit between generation and accumulation

`default_nettype none

module pp_stage_reg (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           in_valid,
  input  wire mul_pipe_pkg::pp_bundle_t pp,
  output mul_pipe_pkg::pp_item_t        item
);

  import mul_pipe_pkg::*;

  logic       valid_q;
  pp_bundle_t pp_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      pp_q <= pp;
    end
  end

  assign item = '{valid: valid_q, pp: pp_q};

endmodule

`default_nettype wire

// ==== partial_products/partial_product_gen.sv ====
// Partial product generation
// Splits both operands into bytes and forms the four 8x8 products,
// approximate for low x low and exact for the other three

`default_nettype none

module partial_product_gen (
  input  wire mul_arith_pkg::operand_t a,
  input  wire mul_arith_pkg::operand_t b,
  output mul_pipe_pkg::pp_bundle_t     pp
);

  import mul_arith_pkg::*;

  half_t  a_lo;
  half_t  a_hi;
  half_t  b_lo;
  half_t  b_hi;
  pprod_t ll;
  pprod_t lh;
  pprod_t hl;
  pprod_t hh;

  assign a_lo = a[HALF_W-1:0];
  assign a_hi = a[OPERAND_W-1:HALF_W];
  assign b_lo = b[HALF_W-1:0];
  assign b_hi = b[OPERAND_W-1:HALF_W];

  // All of the error comes from here
  approx_mul8 u_ll (.a(a_lo), .b(b_lo), .p(ll));

  array_mul8 u_lh (.a(a_lo), .b(b_hi), .p(lh));
  array_mul8 u_hl (.a(a_hi), .b(b_lo), .p(hl));
  array_mul8 u_hh (.a(a_hi), .b(b_hi), .p(hh));

  assign pp = '{ll: ll, lh: lh, hl: hl, hh: hh};

endmodule

`default_nettype wire

// ==== partial_products/array_mul8.sv ====
// Exact 8x8 unsigned array multiplier
// AND rows reduced by carry-save full-adder rows, upper byte from a
// final ripple row

`default_nettype none

module array_mul8 (
  input  wire mul_arith_pkg::half_t a,
  input  wire mul_arith_pkg::half_t b,
  output mul_arith_pkg::pprod_t     p
);

  import mul_arith_pkg::*;

  // Bit i of s and c sits at column i + row
  logic [HALF_W-1:0] s;
  logic [HALF_W-1:0] c;
  logic [HALF_W-1:0] s_nxt;
  logic [HALF_W-1:0] c_nxt;
  logic [HALF_W-1:0] lo;
  logic [HALF_W-1:0] hi;
  logic              rc;

  function automatic logic [1:0] full_add(input logic x, input logic y, input logic z);
    return {(x & y) | (y & z) | (x & z), x ^ y ^ z};
  endfunction

  always_comb begin
    s     = a & {HALF_W{b[0]}};
    c     = '0;
    lo[0] = s[0];
    for (int j = 1; j < HALF_W; j++) begin
      for (int i = 0; i < HALF_W - 1; i++) begin
        {c_nxt[i], s_nxt[i]} = full_add(a[i] & b[j], s[i+1], c[i]);
      end
      // Leftmost cell has no sum from the row above
      {c_nxt[HALF_W-1], s_nxt[HALF_W-1]} = full_add(a[HALF_W-1] & b[j], 1'b0,
                                                    c[HALF_W-1]);
      s     = s_nxt;
      c     = c_nxt;
      lo[j] = s[0];
    end

    // Ripple row merges the last sums and carries
    rc = 1'b0;
    for (int i = 0; i < HALF_W - 1; i++) begin
      {rc, hi[i]} = full_add(s[i+1], c[i], rc);
    end
    hi[HALF_W-1] = c[HALF_W-1] ^ rc;
  end

  assign p = {hi, lo};

endmodule

`default_nettype wire

// ==== partial_products/approx_mul8.sv ====
// Approximate 8x8 unsigned multiplier
// Pareto-optimal gate circuit with a worst-case error of 508, rebuilt
// row by row. Rows a3..a7 are reduced with sum and carry terms, rows
// a1/a2 feed only the top columns, and the low byte keeps the
// circuit's shortcuts

`default_nettype none

module approx_mul8 (
  input  wire mul_arith_pkg::half_t a,
  input  wire mul_arith_pkg::half_t b,
  output mul_arith_pkg::pprod_t     p
);

  import mul_arith_pkg::*;

  logic              hi_or;
  logic              row2_top;
  logic              row2_mid;
  logic              row6_sum;
  logic [HALF_W-1:0] acc;
  logic [HALF_W-1:0] nxt;
  logic              cin;
  logic              y;

  // Rows a1 and a2 collapse into two terms
  assign hi_or    = (a[2] & b[6]) | (a[1] & b[7]);
  assign row2_top = (a[2] & b[7]) & hi_or;
  assign row2_mid = ((b[6] & b[7] & a[2] & a[1]) ^ (a[2] & b[7])) ^ hi_or;

  // Lone a6.b1 term folded with b5
  assign row6_sum = b[5] ^ (a[6] & b[1]);

  // Row k adds a[k] & b[7-k+1 .. 7] onto the k-bit running vector
  always_comb begin
    acc    = '0;
    acc[0] = a[3] & b[4];
    acc[1] = row2_mid;
    acc[2] = row2_top;
    for (int k = 3; k < HALF_W; k++) begin
      // Carry into the lowest cell
      case (k)
        4, 5: begin
          cin = a[k] & b[7-k];
        end
        6: begin
          cin = b[5] & a[6] & b[1];
        end
        default: begin
          cin = 1'b0;
        end
      endcase
      nxt = '0;
      for (int i = 0; i < k; i++) begin
        y      = a[k] & b[HALF_W-k+i];
        nxt[i] = acc[i] ^ y ^ cin;
        if (i < k - 1) begin
          cin = (acc[i] & y) | ((acc[i] ^ y) & cin);
        end else if (k == HALF_W - 1) begin
          // Top cell of the last row
          cin = (acc[i] & a[7]) | (y & cin);
        end else begin
          cin = (acc[i] & y) | (b[7] & cin);
        end
      end
      nxt[k] = cin;
      acc    = nxt;
    end
  end

  assign p[2*HALF_W-1:HALF_W] = acc;

  // Low byte: copied inputs, a constant and a few single gates
  assign p[HALF_W-1:0] = {
    row6_sum,
    a[0],
    a[7] & b[1],
    a[0],
    1'b0,
    a[7] & b[3],
    a[5] & b[4],
    row6_sum
  };

endmodule

`default_nettype wire

// ==== common/mul_pipe_pkg.sv ====
// Pipeline payload types for the 16x16 approximate multiplier
// Carries the four partial products of one operand pair between stages

`default_nettype none

package mul_pipe_pkg;

  // Four 8x8 products of one operand pair
  typedef struct packed {
    mul_arith_pkg::pprod_t ll;
    mul_arith_pkg::pprod_t lh;
    mul_arith_pkg::pprod_t hl;
    mul_arith_pkg::pprod_t hh;
  } pp_bundle_t;

  // Bundle qualified by its valid strobe
  typedef struct packed {
    logic       valid;
    pp_bundle_t pp;
  } pp_item_t;

endpackage

`default_nettype wire

// ==== common/mul_arith_pkg.sv ====
// Arithmetic definitions for the 16x16 approximate multiplier
// Operand, half-operand and product widths and their vector types,
// plus the error bound of the approximate low x low circuit

`default_nettype none

package mul_arith_pkg;

  // The 8x8 gate circuit fixes the half width
  localparam int HALF_W    = 8;
  localparam int OPERAND_W = 2 * HALF_W;
  localparam int PRODUCT_W = 2 * OPERAND_W;

  // One byte of an operand
  typedef logic [HALF_W-1:0] half_t;

  // Full operand
  typedef logic [OPERAND_W-1:0] operand_t;

  // Product of two halves
  typedef logic [2*HALF_W-1:0] pprod_t;

  // Full 32-bit result
  typedef logic [PRODUCT_W-1:0] product_t;

  // Worst-case absolute error of the approximate low x low product.
  // The three exact partial products add nothing to it.
  localparam int unsigned APPROX_WCE = 508;

endpackage

`default_nettype wire
